//--- include/cpu_defs_defs.svh
`ifndef CPU_DEFS_DEFS_SVH
`define CPU_DEFS_DEFS_SVH

// axi-lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// one strobe bit per byte lane
`define AXI_STRB_W (`AXI_DATA_W / 8)

// pc after reset, also the first sram word
`define CPU_RESET_ADDR 32'h8000_0000

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

// sram size in words
`define ISRAM_DEPTH_WORDS 256

// cycles between ar handshake and rvalid
`define ISRAM_READ_WAIT 3

`endif

//--- src/axi_pkg.sv
`default_nettype none

`include "cpu_defs_defs.svh"

package axi_pkg;

    // bus vectors
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]             axi_resp_t;

    // response codes, exokay and decerr never produced here
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- src/core_pkg.sv
`default_nettype none

`include "cpu_defs_defs.svh"

package core_pkg;

    // program counter and instruction word
    typedef logic [`AXI_ADDR_W-1:0] pc_t;
    typedef logic [`AXI_DATA_W-1:0] inst_t;

    // instruction sram slave
    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_RD_WAIT,
        SRAM_RD_RESP,
        SRAM_WR_RESP
    } sram_state_e;

    // fetch unit read master
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA
    } fetch_state_e;

    // loader write master
    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_SEND,
        LOAD_RESP
    } loader_state_e;

endpackage

`default_nettype wire

//--- src/isram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs_defs.svh"

module isram
    import axi_pkg::*;
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // read address
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    // read data
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,
    // write address
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    // write data
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    // write response
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready
);

    localparam int IDX_W  = $clog2(`ISRAM_DEPTH_WORDS);
    localparam int WAIT_W = (`ISRAM_READ_WAIT > 1) ? $clog2(`ISRAM_READ_WAIT) : 1;

    // mapped window [base, end)
    localparam axi_addr_t SRAM_BASE = `CPU_RESET_ADDR;
    localparam axi_addr_t SRAM_END  = SRAM_BASE + axi_addr_t'(4 * `ISRAM_DEPTH_WORDS);

    // last count of the read wait
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`ISRAM_READ_WAIT - 1);

    axi_data_t         mem [`ISRAM_DEPTH_WORDS];
    sram_state_e       state;
    logic [WAIT_W-1:0] wait_cnt;
    axi_addr_t         rd_addr;

    logic wr_fire;
    logic ar_fire;
    logic rd_last;

    function automatic logic in_range(input axi_addr_t addr);
        return (addr >= SRAM_BASE) && (addr < SRAM_END);
    endfunction

    // word index from byte address with low two bits dropped
    function automatic logic [IDX_W-1:0] word_idx(input axi_addr_t addr);
        axi_addr_t offset;
        offset = addr - SRAM_BASE;
        return offset[IDX_W+1:2];
    endfunction

    // write wins in idle with aw and w taken together
    assign awready = (state == SRAM_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign wr_fire = awready;

    // reads held off while any write channel is pending
    assign arready = (state == SRAM_IDLE) && !awvalid && !wvalid;
    assign ar_fire = arvalid && arready;

    // data sampled in the final wait cycle
    assign rd_last = (state == SRAM_RD_WAIT) && (wait_cnt == WAIT_LAST);

    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SRAM_IDLE;
            wait_cnt <= '0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            case (state)
                SRAM_IDLE: begin
                    if (wr_fire) begin
                        // memory written this edge and b follows next cycle
                        state  <= SRAM_WR_RESP;
                        bvalid <= 1'b1;
                    end else if (ar_fire) begin
                        state    <= SRAM_RD_WAIT;
                        wait_cnt <= '0;
                    end
                end
                SRAM_RD_WAIT: begin
                    if (rd_last) begin
                        state  <= SRAM_RD_RESP;
                        rvalid <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + WAIT_W'(1);
                    end
                end
                SRAM_RD_RESP: begin
                    // hold until master takes it
                    if (rready) begin
                        state  <= SRAM_IDLE;
                        rvalid <= 1'b0;
                    end
                end
                SRAM_WR_RESP: begin
                    if (bready) begin
                        state  <= SRAM_IDLE;
                        bvalid <= 1'b0;
                    end
                end
                default: begin
                    state <= SRAM_IDLE;
                end
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
        end
        if (rd_last) begin
            if (in_range(rd_addr)) begin
                rdata <= mem[word_idx(rd_addr)];
                rresp <= RESP_OKAY;
            end else begin
                // unmapped fetch sees a nop
                rdata <= `INST_NOP;
                rresp <= RESP_SLVERR;
            end
        end
        if (wr_fire) begin
            bresp <= in_range(awaddr) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // byte-lane merge that drops out-of-range writes
    always_ff @(posedge clk) begin
        if (wr_fire && in_range(awaddr)) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[word_idx(awaddr)][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // rvalid only in the response state
    a_rvalid_in_resp: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid |-> state == SRAM_RD_RESP);

    // read payload held while stalled
    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

//--- src/ifu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs_defs.svh"

module ifu
    import axi_pkg::*;
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // core side
    input  logic      fetch_en,
    input  logic      redirect,
    input  pc_t       redirect_pc,
    output logic      inst_valid,
    output inst_t     inst,
    output pc_t       inst_pc,
    output logic      inst_err,
    // read address
    output axi_addr_t araddr,
    output logic      arvalid,
    input  logic      arready,
    // read data
    input  axi_data_t rdata,
    input  axi_resp_t rresp,
    input  logic      rvalid,
    output logic      rready
);

    fetch_state_e state;
    pc_t          pc;
    // response belongs to an abandoned pc
    logic         drop;

    logic ar_fire;
    logic r_fire;
    logic keep;

    // never stalls the slave
    assign rready = 1'b1;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // response reported only if nothing redirected it
    assign keep = !drop && !redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FETCH_IDLE;
            pc         <= `CPU_RESET_ADDR;
            arvalid    <= 1'b0;
            drop       <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            // redirect loads pc in any state
            if (redirect) begin
                pc <= redirect_pc;
            end
            case (state)
                FETCH_IDLE: begin
                    if (fetch_en) begin
                        state   <= FETCH_ADDR;
                        arvalid <= 1'b1;
                    end
                end
                FETCH_ADDR: begin
                    // ar must still complete, mark the answer stale
                    if (redirect) begin
                        drop <= 1'b1;
                    end
                    if (ar_fire) begin
                        state   <= FETCH_DATA;
                        arvalid <= 1'b0;
                    end
                end
                FETCH_DATA: begin
                    if (r_fire) begin
                        state      <= FETCH_IDLE;
                        drop       <= 1'b0;
                        inst_valid <= keep;
                        if (keep) begin
                            pc <= pc + pc_t'(4);
                        end
                    end else if (redirect) begin
                        drop <= 1'b1;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && fetch_en) begin
            // same-cycle redirect goes straight to the bus
            araddr <= redirect ? redirect_pc : pc;
        end
        if (r_fire) begin
            inst     <= rdata;
            inst_pc  <= araddr;
            inst_err <= (rresp == RESP_SLVERR);
        end
    end

    // address held until accepted
    a_araddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

//--- src/imem_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs_defs.svh"

module imem_loader
    import axi_pkg::*;
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // outside strobe
    input  logic      load_valid,
    input  axi_addr_t load_addr,
    input  axi_data_t load_data,
    input  axi_strb_t load_strb,
    output logic      load_done,
    output logic      load_err,
    // write address
    output axi_addr_t awaddr,
    output logic      awvalid,
    input  logic      awready,
    // write data
    output axi_data_t wdata,
    output axi_strb_t wstrb,
    output logic      wvalid,
    input  logic      wready,
    // write response
    input  axi_resp_t bresp,
    input  logic      bvalid,
    output logic      bready
);

    loader_state_e state;

    // channel finished by the end of this cycle
    logic aw_done;
    logic w_done;
    logic b_fire;

    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    // response always accepted
    assign bready = 1'b1;
    assign b_fire = bvalid && bready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= LOAD_IDLE;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (state)
                LOAD_IDLE: begin
                    if (load_valid) begin
                        state   <= LOAD_SEND;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end
                end
                LOAD_SEND: begin
                    // aw and w may be taken on different cycles
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= LOAD_RESP;
                    end
                end
                LOAD_RESP: begin
                    if (b_fire) begin
                        state     <= LOAD_IDLE;
                        load_done <= 1'b1;
                    end
                end
                default: begin
                    state <= LOAD_IDLE;
                end
            endcase
        end
    end

    // request latched once, error with the done pulse
    always_ff @(posedge clk) begin
        if (state == LOAD_IDLE && load_valid) begin
            awaddr <= load_addr;
            wdata  <= load_data;
            wstrb  <= load_strb;
        end
        if (state == LOAD_RESP && b_fire) begin
            load_err <= (bresp == RESP_SLVERR);
        end
    end

    // no back-pressure outside, a new load must wait for done
    a_load_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> state == LOAD_IDLE);

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs_defs.svh"

module fetch_top
    import axi_pkg::*;
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // program load
    input  logic      load_valid,
    input  axi_addr_t load_addr,
    input  axi_data_t load_data,
    input  axi_strb_t load_strb,
    output logic      load_done,
    output logic      load_err,
    // fetch
    input  logic      fetch_en,
    input  logic      redirect,
    input  pc_t       redirect_pc,
    output logic      inst_valid,
    output inst_t     inst,
    output pc_t       inst_pc,
    output logic      inst_err
);

    // read channels, ifu to sram
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    // write channels, loader to sram
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;

    imem_loader i_imem_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_strb  (load_strb),
        .load_done  (load_done),
        .load_err   (load_err),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    ifu i_ifu (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_err    (inst_err),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    // single slave, serves the loader before the fetch unit
    isram i_isram (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs_defs.svh"

module tb_fetch;

    localparam logic [31:0] SRAM_BASE = `CPU_RESET_ADDR;
    localparam logic [31:0] SRAM_END  = SRAM_BASE + 32'(4 * `ISRAM_DEPTH_WORDS);
    // about 50 loads and 150 fetches at under 8 cycles each plus wide margin
    localparam int CYCLE_LIMIT = 20000;

    logic                   clk;
    logic                   rst_n;
    logic                   load_valid;
    logic [31:0]            load_addr;
    logic [31:0]            load_data;
    logic [`AXI_STRB_W-1:0] load_strb;
    logic                   load_done;
    logic                   load_err;
    logic                   fetch_en;
    logic                   redirect;
    logic [31:0]            redirect_pc;
    logic                   inst_valid;
    logic [31:0]            inst;
    logic [31:0]            inst_pc;
    logic                   inst_err;

    // shadow copy of the sram contents
    logic [31:0] shadow [`ISRAM_DEPTH_WORDS];
    logic [31:0] exp_pc;
    logic [32:0] expected;
    logic [31:0] lfsr_state = 32'h43be8ca6;
    int          cycle_count = 0;

    fetch_top i_fetch_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_strb   (load_strb),
        .load_done   (load_done),
        .load_err    (load_err),
        .fetch_en    (fetch_en),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_err    (inst_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic sram_hit(input logic [31:0] addr);
        return (addr >= SRAM_BASE) && (addr < SRAM_END);
    endfunction

    // expected {err, word} for a fetch from pc
    function automatic logic [32:0] exp_fetch(input logic [31:0] pc);
        logic [31:0] off;
        off = pc - SRAM_BASE;
        if (!sram_hit(pc)) begin
            return {1'b1, `INST_NOP};
        end
        return {1'b0, shadow[off[9:2]]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // one write through the loader with the shadow updated on success
    task automatic load_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [`AXI_STRB_W-1:0] strb);
        logic [31:0] off;
        off = addr - SRAM_BASE;
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        load_strb  = strb;
        @(negedge clk);
        load_valid = 1'b0;
        while (!load_done) @(negedge clk);
        check_value("load_err", 32'(load_err), 32'(!sram_hit(addr)));
        if (sram_hit(addr)) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (strb[b]) begin
                    shadow[off[9:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    // fetch_en dropped on the last strobe before the fsm leaves idle
    task automatic fetch_words(input int n);
        int got;
        got = 0;
        fetch_en = 1'b1;
        while (got < n) begin
            @(negedge clk);
            if (inst_valid) got++;
        end
        fetch_en = 1'b0;
    endtask

    // pc load while the fetch unit is idle
    task automatic jump_to(input logic [31:0] pc);
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = pc;
        exp_pc      = pc;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    // redirect lands while the next read is in flight
    task automatic fetch_with_redirect(input int n_after);
        logic [31:0] r;
        logic [31:0] target;
        int          delay;
        int          got;
        r      = rand_bits(2);
        delay  = 1 + int'(r[1:0]);
        r      = rand_bits(4);
        target = SRAM_BASE + 32'(4 * int'(r[3:0]));
        got    = 0;
        fetch_en = 1'b1;
        @(negedge clk);
        while (!inst_valid) @(negedge clk);
        repeat (delay) @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = target;
        exp_pc      = target;
        @(negedge clk);
        redirect = 1'b0;
        while (got < n_after) begin
            if (inst_valid) got++;
            if (got < n_after) @(negedge clk);
        end
        fetch_en = 1'b0;
    endtask

    // every strobe checked against the model
    always @(negedge clk) begin
        if (rst_n && inst_valid) begin
            expected = exp_fetch(exp_pc);
            check_value("inst_pc", inst_pc, exp_pc);
            check_value("inst", inst, expected[31:0]);
            check_value("inst_err", 32'(inst_err), 32'(expected[32]));
            exp_pc = exp_pc + 32'd4;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        logic [31:0]            r;
        logic [31:0]            data;
        logic [`AXI_STRB_W-1:0] strb;
        rst_n       = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        load_strb   = '0;
        fetch_en    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        exp_pc      = `CPU_RESET_ADDR;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // quiet after reset
        repeat (20) begin
            @(negedge clk);
            check_value("inst_valid", 32'(inst_valid), 32'd0);
            check_value("load_done", 32'(load_done), 32'd0);
        end

        // program load and straight-line fetch from the reset pc
        for (int i = 0; i < 32; i++) begin
            load_word(SRAM_BASE + 32'(4 * i), rand_bits(32), '1);
        end
        fetch_words(32);

        // partial strobes over written words
        for (int i = 0; i < 8; i++) begin
            r    = rand_bits(4);
            strb = r[`AXI_STRB_W-1:0];
            if (strb == '1 || strb == '0) strb = 4'b0110;
            r    = rand_bits(5);
            data = rand_bits(32);
            load_word(SRAM_BASE + 32'(4 * int'(r[4:0])), data, strb);
        end
        jump_to(SRAM_BASE);
        fetch_words(32);

        // redirects with a read outstanding
        jump_to(SRAM_BASE);
        for (int i = 0; i < 4; i++) begin
            fetch_with_redirect(8);
        end

        // last mapped word gets known contents
        load_word(SRAM_END - 32'd4, rand_bits(32), '1);

        // unmapped writes leave the array alone even where they alias
        load_word(SRAM_END, rand_bits(32), '1);
        load_word(SRAM_END + 32'd12, rand_bits(32), '1);
        load_word(SRAM_BASE - 32'd4, rand_bits(32), '1);
        jump_to(SRAM_BASE);
        fetch_words(32);

        // last mapped word and on past the end
        jump_to(SRAM_END - 32'd4);
        fetch_words(5);
        // below the base
        jump_to(32'h0000_0100);
        fetch_words(2);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/axi_pkg.sv
src/core_pkg.sv
src/isram.sv
src/ifu.sv
src/imem_loader.sv
src/fetch_top.sv
testbench/tb_fetch.sv

//--- Makefile
# Verilator simulation of the instruction fetch subsystem
TOP = tb_fetch

.PHONY: all run lint clean

all: run

# exit status is nonzero when the testbench hits $fatal
run:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
